//--- verilog/mem_types_pkg.sv
package mem_types_pkg;

    // byte address as issued by the core
    typedef logic [31:0] addr_t;

    // one instruction or data word
    typedef logic [31:0] word_t;

    // per-bit write enable, 1 takes the new bit
    typedef logic [31:0] mask_t;

    // access statistics counter
    typedef logic [15:0] count_t;

endpackage

//--- verilog/mem_cfg_pkg.sv
package mem_cfg_pkg;

    localparam int MEM_WORDS    = 4096;                     // RAM depth in words
    localparam int READ_LATENCY = 2;                        // accept to rdata_valid
    localparam int ADDR_LSB     = 2;                        // byte offset bits dropped
    localparam int IDX_W        = $clog2(MEM_WORDS);        // word index width
    localparam int LAT_W        = $clog2(READ_LATENCY + 1); // read delay counter width

    // arbiter FSM
    typedef enum logic [1:0] {
        wait_cmd,       // idle, core requests taken here
        wait_mem_ready, // command saved, memory busy
        wait_mem_read   // read in flight
    } arb_state_t;

endpackage

//--- verilog/mem_bus_if.sv
interface mem_bus_if;
    import mem_types_pkg::*;

    logic  cmd_start;   // command valid this cycle
    logic  cmd_write;   // 1 store, 0 read
    addr_t addr;
    word_t wdata;
    mask_t wmask;
    logic  cmd_ready;   // memory can take a command
    word_t rdata;
    logic  rdata_valid; // one-cycle read return

    modport master (
        output cmd_start,
        output cmd_write,
        output addr,
        output wdata,
        output wmask,
        input  cmd_ready,
        input  rdata,
        input  rdata_valid
    );

    modport slave (
        input  cmd_start,
        input  cmd_write,
        input  addr,
        input  wdata,
        input  wmask,
        output cmd_ready,
        output rdata,
        output rdata_valid
    );

endinterface

//--- verilog/mem_arbiter.sv
module mem_arbiter (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 inst_start,
    input  mem_types_pkg::addr_t i_addr,
    output logic                 inst_ready,
    output mem_types_pkg::word_t inst,
    output logic                 inst_valid,

    input  logic                 d_cmd_start,
    input  logic                 d_cmd_write,
    input  mem_types_pkg::addr_t d_addr,
    input  mem_types_pkg::word_t wdata,
    input  mem_types_pkg::mask_t wmask,
    output logic                 d_cmd_ready,
    output mem_types_pkg::word_t rdata,
    output logic                 rdata_valid,

    input  logic                 halted,
    output logic                 fetch_acc,
    output logic                 load_acc,
    output logic                 store_acc,

    mem_bus_if.master            bus
);
    import mem_types_pkg::*;
    import mem_cfg_pkg::*;

    arb_state_t state;
    logic       cmd_is_inst;  // fetch owns the bus
    logic       save_d_start; // data command parked behind a fetch
    logic       save_d_write;
    addr_t      save_i_addr;
    addr_t      save_d_addr;
    word_t      save_wdata;
    mask_t      save_wmask;
    word_t      inst_q;
    word_t      rdata_q;

    logic       core_go;
    logic       take_inst;
    logic       take_data;
    logic       bus_is_inst;
    logic       bus_acc;

    assign core_go   = (state == wait_cmd) && !halted;
    assign take_inst = core_go && inst_start;
    assign take_data = core_go && d_cmd_start;

    assign inst_ready  = core_go;
    assign d_cmd_ready = core_go;

    // live request while idle, saved copy otherwise
    always_comb begin
        bus.cmd_start = 1'b0;
        bus.cmd_write = 1'b0;
        bus.addr      = save_d_addr;
        bus.wdata     = save_wdata;
        bus.wmask     = save_wmask;
        bus_is_inst   = 1'b0;
        case (state)
            wait_cmd: begin
                bus.cmd_start = take_inst || take_data;
                bus.cmd_write = !take_inst && d_cmd_write; // fetch goes first
                bus.addr      = take_inst ? i_addr : d_addr;
                bus.wdata     = wdata;
                bus.wmask     = wmask;
                bus_is_inst   = take_inst;
            end
            wait_mem_ready: begin
                bus.cmd_start = 1'b1;
                bus.cmd_write = !cmd_is_inst && save_d_write;
                bus.addr      = cmd_is_inst ? save_i_addr : save_d_addr;
                bus_is_inst   = cmd_is_inst;
            end
            wait_mem_read: begin
                // parked data command goes out as the fetch returns
                bus.cmd_start = bus.rdata_valid && cmd_is_inst && save_d_start;
                bus.cmd_write = save_d_write;
            end
            default: begin
            end
        endcase
    end

    assign bus_acc   = bus.cmd_start && bus.cmd_ready;
    assign fetch_acc = bus_acc && bus_is_inst;
    assign load_acc  = bus_acc && !bus_is_inst && !bus.cmd_write;
    assign store_acc = bus_acc && bus.cmd_write;

    assign inst_valid  = (state == wait_mem_read) && cmd_is_inst && bus.rdata_valid;
    assign rdata_valid = (state == wait_mem_read) && !cmd_is_inst && bus.rdata_valid;

    assign inst  = inst_valid ? bus.rdata : inst_q;   // hold between pulses
    assign rdata = rdata_valid ? bus.rdata : rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= wait_cmd;
            cmd_is_inst  <= 1'b0;
            save_d_start <= 1'b0;
            inst_q       <= '1;
            rdata_q      <= '1;
        end else begin
            case (state)
                wait_cmd: begin
                    if (take_inst || take_data) begin
                        cmd_is_inst  <= take_inst;
                        save_d_start <= take_data;
                        if (!bus.cmd_ready)
                            state <= wait_mem_ready;
                        else if (take_inst || !d_cmd_write)
                            state <= wait_mem_read;
                    end
                end
                wait_mem_ready: begin
                    if (bus.cmd_ready) begin
                        if (cmd_is_inst || !save_d_write)
                            state <= wait_mem_read;
                        else
                            state <= wait_cmd; // store done at this edge
                    end
                end
                wait_mem_read: begin
                    if (bus.rdata_valid) begin
                        if (cmd_is_inst) begin
                            inst_q <= bus.rdata;
                            if (save_d_start) begin
                                cmd_is_inst <= 1'b0;
                                if (!bus.cmd_ready)
                                    state <= wait_mem_ready;
                                else if (save_d_write)
                                    state <= wait_cmd;
                            end else begin
                                state <= wait_cmd;
                            end
                        end else begin
                            rdata_q <= bus.rdata;
                            state   <= wait_cmd;
                        end
                    end
                end
                default: state <= wait_cmd;
            endcase
        end
    end

    // request payload, captured only when taken
    always_ff @(posedge clk) begin
        if (take_inst || take_data) begin
            save_i_addr  <= i_addr;
            save_d_write <= d_cmd_write;
            save_d_addr  <= d_addr;
            save_wdata   <= wdata;
            save_wmask   <= wmask;
        end
    end

endmodule

//--- verilog/mem_controller.sv
module mem_controller (
    input  logic     clk,
    input  logic     rst,
    mem_bus_if.slave bus
);
    import mem_types_pkg::*;
    import mem_cfg_pkg::*;

    word_t             ram [MEM_WORDS];
    word_t             rd_word;    // read result, captured at acceptance
    word_t             cur_word;
    word_t             new_word;
    logic [IDX_W-1:0]  idx;
    logic [LAT_W-1:0]  lat_cnt;    // cycles left until read returns
    logic              accept;
    logic              accept_rd;
    logic              accept_wr;

    assign idx       = bus.addr[ADDR_LSB +: IDX_W]; // upper address bits ignored
    assign accept    = bus.cmd_start && bus.cmd_ready;
    assign accept_rd = accept && !bus.cmd_write;
    assign accept_wr = accept && bus.cmd_write;

    assign cur_word = ram[idx];
    // masked merge, old bits kept where mask is 0
    assign new_word = (cur_word & ~bus.wmask) | (bus.wdata & bus.wmask);

    always_ff @(posedge clk) begin
        if (accept_wr)
            ram[idx] <= new_word;
    end

    always_ff @(posedge clk) begin
        if (accept_rd)
            rd_word <= cur_word;
    end

    // read delay counter
    always_ff @(posedge clk) begin
        if (rst)
            lat_cnt <= '0;
        else if (accept_rd)
            lat_cnt <= LAT_W'(READ_LATENCY);
        else if (lat_cnt != '0)
            lat_cnt <= lat_cnt - 1'b1;
    end

    // ready comes back in the same cycle as the data
    assign bus.cmd_ready   = lat_cnt <= LAT_W'(1);
    assign bus.rdata_valid = lat_cnt == LAT_W'(1);
    assign bus.rdata       = rd_word;

endmodule

//--- verilog/mem_run_ctrl.sv
module mem_run_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  exit_req,
    input  logic                  fetch_acc,
    input  logic                  load_acc,
    input  logic                  store_acc,
    output logic                  halted,
    output mem_types_pkg::count_t fetch_count,
    output mem_types_pkg::count_t load_count,
    output mem_types_pkg::count_t store_count
);
    import mem_types_pkg::*;

    // +1 unless already at the top
    function automatic count_t sat_inc(input count_t cnt, input logic hit);
        if (hit && (cnt != '1))
            return cnt + 1'b1;
        return cnt;
    endfunction

    // sticky halt, only rst clears it
    always_ff @(posedge clk) begin
        if (rst)
            halted <= 1'b0;
        else if (exit_req)
            halted <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_count <= '0;
            load_count  <= '0;
            store_count <= '0;
        end else begin
            fetch_count <= sat_inc(fetch_count, fetch_acc);
            load_count  <= sat_inc(load_count, load_acc);
            store_count <= sat_inc(store_count, store_acc);
        end
    end

endmodule

//--- verilog/mem_interface.sv
module mem_interface (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  inst_start,
    output logic                  inst_ready,
    input  mem_types_pkg::addr_t  i_addr,
    output mem_types_pkg::word_t  inst,
    output logic                  inst_valid,

    input  logic                  d_cmd_start,
    input  logic                  d_cmd_write,
    output logic                  d_cmd_ready,
    input  mem_types_pkg::addr_t  d_addr,
    input  mem_types_pkg::word_t  wdata,
    input  mem_types_pkg::mask_t  wmask,
    output mem_types_pkg::word_t  rdata,
    output logic                  rdata_valid,

    input  logic                  exit_req,
    output logic                  halted,
    output mem_types_pkg::count_t fetch_count,
    output mem_types_pkg::count_t load_count,
    output mem_types_pkg::count_t store_count
);

    logic fetch_acc;  // arbiter acceptance strobes
    logic load_acc;
    logic store_acc;

    mem_bus_if mem_bus ();

    mem_arbiter mem_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .inst_start  (inst_start),
        .i_addr      (i_addr),
        .inst_ready  (inst_ready),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .d_cmd_ready (d_cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .halted      (halted),
        .fetch_acc   (fetch_acc),
        .load_acc    (load_acc),
        .store_acc   (store_acc),
        .bus         (mem_bus.master)
    );

    mem_controller mem_controller_i (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.slave)
    );

    mem_run_ctrl mem_run_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .exit_req    (exit_req),
        .fetch_acc   (fetch_acc),
        .load_acc    (load_acc),
        .store_acc   (store_acc),
        .halted      (halted),
        .fetch_count (fetch_count),
        .load_count  (load_count),
        .store_count (store_count)
    );

endmodule

//--- tb/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 10; // 20 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk); // two reset edges
        #2 rst = 1'b0;
    end

endmodule

//--- tb/mem_interface_tb.sv
module mem_interface_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_types_pkg::*;
    import mem_cfg_pkg::*;

    localparam int SEED      = 50;
    localparam int DRIVE_DLY = 2;   // ns after the rising edge
    localparam int N_POOL    = 16;  // word addresses in use
    localparam int N_MERGE   = 8;
    localparam int N_PAIRS   = 4;
    localparam int N_RANDOM  = 200;
    localparam int NUM_OPS   = 3 * N_POOL + 2 * N_MERGE + 1 + 5 * N_PAIRS + 2 * N_RANDOM + 8;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 4 * READ_LATENCY + 100;

    logic   clk;
    logic   rst;
    logic   inst_start;
    logic   inst_ready;
    addr_t  i_addr;
    word_t  inst;
    logic   inst_valid;
    logic   d_cmd_start;
    logic   d_cmd_write;
    logic   d_cmd_ready;
    addr_t  d_addr;
    word_t  wdata;
    mask_t  wmask;
    word_t  rdata;
    logic   rdata_valid;
    logic   exit_req;
    logic   halted;
    count_t fetch_count;
    count_t load_count;
    count_t store_count;

    word_t  model [MEM_WORDS];  // reference memory
    int     pool [N_POOL];
    word_t  inst_exp_q [$];
    int     inst_cyc_q [$];     // cycle the pulse is due
    word_t  rdata_exp_q [$];
    int     rdata_cyc_q [$];
    int     cycle = 0;
    int     n_fetch = 0;
    int     n_load = 0;
    int     n_store = 0;

    clk_gen clk_gen_i (.clk(clk), .rst(rst));

    mem_interface mem_interface_i (.*);

    always @(posedge clk) cycle <= cycle + 1;

    // each set mask bit picks the new data bit
    function automatic word_t merge_word(word_t old_w, word_t new_w, mask_t m);
        word_t res;
        for (int b = 0; b < $bits(word_t); b++)
            res[b] = m[b] ? new_w[b] : old_w[b];
        return res;
    endfunction

    // upper address bits stay random since the RAM ignores them
    function automatic addr_t word_addr(int idx);
        addr_t a;
        a = $urandom;
        a[ADDR_LSB +: IDX_W] = idx[IDX_W-1:0];
        a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic int any_pool();
        return pool[$urandom % N_POOL];
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("** Error at %0t ns: %s = %h, expected %h",
                                     $time, name, got, exp));
    endtask

    // waits for ready, drives one request for a cycle and books its results
    task automatic issue(input bit fetch, input bit data, input bit write, input int f_idx,
                         input int d_idx, input word_t wd, input mask_t wm);
        int acc;
        int d_acc;
        while ((fetch && !inst_ready) || (data && !d_cmd_ready)) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        acc         = cycle;
        d_acc       = fetch ? acc + READ_LATENCY : acc; // data waits behind the fetch
        inst_start  = fetch;
        i_addr      = word_addr(f_idx);
        d_cmd_start = data;
        d_cmd_write = write;
        d_addr      = word_addr(d_idx);
        wdata       = wd;
        wmask       = wm;
        if (fetch) begin
            inst_exp_q.push_back(model[f_idx]);
            inst_cyc_q.push_back(acc + READ_LATENCY);
            n_fetch++;
        end
        if (data && write) begin
            model[d_idx] = merge_word(model[d_idx], wd, wm);
            n_store++;
        end else if (data) begin
            rdata_exp_q.push_back(model[d_idx]);
            rdata_cyc_q.push_back(d_acc + READ_LATENCY);
            n_load++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        if (data && write && !fetch)
            check_value("d_cmd_ready", d_cmd_ready, 1'b1);
    endtask

    task automatic drain();
        while (inst_exp_q.size() != 0 || rdata_exp_q.size() != 0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // mid-cycle compare of every returned word
    always @(negedge clk) begin
        if (!rst && inst_valid) begin
            if (inst_exp_q.size() == 0) begin
                report_failure("inst_valid pulsed while no fetch was outstanding");
            end else begin
                check_value("inst", inst, inst_exp_q.pop_front());
                check_value("inst_valid cycle", cycle, inst_cyc_q.pop_front());
            end
        end
        if (!rst && rdata_valid) begin
            if (rdata_exp_q.size() == 0) begin
                report_failure("rdata_valid pulsed while no load was outstanding");
            end else begin
                check_value("rdata", rdata, rdata_exp_q.pop_front());
                check_value("rdata_valid cycle", cycle, rdata_cyc_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("timeout after %0d cycles with results still missing",
                                 WATCHDOG_CYCLES));
    end

    initial begin
        int    op;
        int    k;
        mask_t m;
        void'($urandom(SEED));
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        exit_req    = 1'b0;
        for (int i = 0; i < N_POOL; i++)
            pool[i] = $urandom % MEM_WORDS;
        @(negedge rst);

        check_value("inst_ready", inst_ready, 1'b1);
        check_value("d_cmd_ready", d_cmd_ready, 1'b1);
        check_value("inst_valid", inst_valid, 1'b0);
        check_value("rdata_valid", rdata_valid, 1'b0);
        check_value("halted", halted, 1'b0);
        check_value("fetch_count", fetch_count, 0);
        check_value("load_count", load_count, 0);
        check_value("store_count", store_count, 0);
        check_value("inst", inst, 32'hffff_ffff);
        check_value("rdata", rdata, 32'hffff_ffff);

        for (int i = 0; i < N_POOL; i++)
            issue(0, 1, 1, 0, pool[i], $urandom, '1);
        for (int i = 0; i < N_POOL; i++)
            issue(0, 1, 0, 0, pool[i], '0, '0);
        drain();

        issue(0, 1, 1, 0, pool[0], 32'hc3a5_5a3c, '1);   // known word for merges
        for (int i = 0; i < N_MERGE; i++) begin
            issue(0, 1, 1, 0, pool[0], $urandom, $urandom);
            issue(0, 1, 0, 0, pool[0], '0, '0);
        end
        drain();

        for (int i = 0; i < N_POOL; i++)
            issue(1, 0, 0, pool[i], 0, '0, '0);
        for (int i = 0; i < N_PAIRS; i++) begin
            k = any_pool();
            issue(1, 1, 0, any_pool(), k, '0, '0);
            issue(1, 1, 1, any_pool(), k, $urandom, '1);
            issue(0, 1, 0, 0, k, '0, '0);                  // sees the paired store
        end
        drain();

        for (int i = 0; i < N_RANDOM; i++) begin
            op = $urandom % 5;                             // 3 and 4 are pairs
            m  = ($urandom % 2) ? $urandom : '1;
            issue(op == 0 || op > 2, op != 0, op == 2 || op == 4,
                  any_pool(), any_pool(), $urandom, m);
        end
        drain();

        issue(0, 1, 0, 0, pool[1], '0, '0);                // in flight at halt
        exit_req = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        exit_req = 1'b0;
        drain();
        check_value("halted", halted, 1'b1);
        inst_start  = 1'b1;
        d_cmd_start = 1'b1;
        d_cmd_write = 1'b0;
        repeat (3 * READ_LATENCY) begin
            check_value("inst_ready", inst_ready, 1'b0);
            check_value("d_cmd_ready", d_cmd_ready, 1'b0);
            @(posedge clk);
            #DRIVE_DLY;
        end
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        repeat (2 * READ_LATENCY) @(posedge clk);
        #DRIVE_DLY;
        check_value("fetch_count", fetch_count, n_fetch);
        check_value("load_count", load_count, n_load);
        check_value("store_count", store_count, n_store);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- mem_interface.f
verilog/mem_types_pkg.sv
verilog/mem_cfg_pkg.sv
verilog/mem_bus_if.sv
verilog/mem_arbiter.sv
verilog/mem_controller.sv
verilog/mem_run_ctrl.sv
verilog/mem_interface.sv
tb/clk_gen.sv
tb/mem_interface_tb.sv

//--- Makefile
TOP := mem_interface_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f mem_interface.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
